// ==== dv/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_tb;

	localparam int W = `CONV_IMG_W;
	localparam int N_PIX = `CONV_IMG_W * `CONV_IMG_H;
	localparam int N_WT = `CONV_TAPS * `CONV_OUT_CH;
	localparam int OUT_W = `CONV_IMG_W - 2;
	localparam int N_SAVE = OUT_W * (`CONV_IMG_H - 2);
	localparam int DRIVE_DLY = 5;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst;
	logic weight_store_done;
	logic pixel_store_done;
	logic save_enable;
	logic calculation_done;
	logic read_pixel_signal;
	logic read_weight_signal;
	logic read_bias_signal;
	logic [`CONV_ADDR_W-1:0] output_row;
	logic [`CONV_ADDR_W-1:0] output_col;
	logic [`CONV_ADDR_W-1:0] read_row_addr;
	logic [`CONV_ADDR_W-1:0] read_col_addr;
	logic [`CONV_ADDR_W-1:0] read_weight_addr;
	logic [`CONV_ADDR_W-1:0] read_bias_addr;
	conv_pkg::pixel_t input_data;
	conv_pkg::pixel_t weight_data;
	conv_pkg::data_t bias_data;
	conv_pkg::result_t output_data;

	conv_pkg::pixel_t pix_mem [N_PIX];
	conv_pkg::pixel_t wt_mem [N_WT];
	conv_pkg::data_t bias_mem [`CONV_OUT_CH];

	logic [31:0] lfsr;
	int errors;
	int tests_run;
	int tests_failed;
	bit frame_started;
	bit frame_done_seen;
	bit done_with_save;
	logic [`CONV_ADDR_W-1:0] done_row;
	logic [`CONV_ADDR_W-1:0] done_col;

	conv_top dut_i (
		.clk                (clk),
		.rst                (rst),
		.input_data         (input_data),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.weight_store_done  (weight_store_done),
		.pixel_store_done   (pixel_store_done),
		.save_enable        (save_enable),
		.calculation_done   (calculation_done),
		.read_pixel_signal  (read_pixel_signal),
		.read_weight_signal (read_weight_signal),
		.read_bias_signal   (read_bias_signal),
		.output_row         (output_row),
		.output_col         (output_col),
		.read_row_addr      (read_row_addr),
		.read_col_addr      (read_col_addr),
		.read_weight_addr   (read_weight_addr),
		.read_bias_addr     (read_bias_addr),
		.output_data        (output_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// synchronous memories, data one cycle after the strobe
	initial
	begin
		bit w_pend;
		bit b_pend;
		bit p_pend;
		int w_idx;
		int b_idx;
		int p_idx;
		w_pend = 0;
		b_pend = 0;
		p_pend = 0;
		forever
		begin
			@(posedge clk);
			#DRIVE_DLY;
			if (w_pend && w_idx < N_WT)
				weight_data = wt_mem[w_idx];
			if (b_pend && b_idx < `CONV_OUT_CH)
				bias_data = bias_mem[b_idx];
			if (p_pend && p_idx < N_PIX)
				input_data = pix_mem[p_idx];
			w_pend = read_weight_signal;
			b_pend = read_bias_signal;
			p_pend = read_pixel_signal;
			w_idx = read_weight_addr;
			b_idx = read_bias_addr;
			p_idx = read_row_addr * W + read_col_addr;
		end
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// full products shifted, 32-bit sum, bias sign extended, low half kept
	function automatic logic [15:0] model_result(int orow, int ocol, int ch);
		logic signed [31:0] acc;
		logic signed [31:0] prod;
		int idx;
		acc = $signed(bias_mem[ch]);
		for (int dr = 0; dr < 3; dr++)
			for (int dc = 0; dc < 3; dc++)
				for (int i = 0; i < `CONV_IN_CH; i++)
				begin
					idx = (orow + dr) * W + ocol + dc;
					prod = $signed(pix_mem[idx][i])
						* $signed(wt_mem[(dr * 3 + dc) * `CONV_OUT_CH + ch][i]);
					acc = acc + (prod >>> `CONV_FRAC);
				end
		return acc[15:0];
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("MISMATCH %s: expected %h, got %h", name, exp, act);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errs0);
		tests_run++;
		if (errors == errs0)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errs0);
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) next_cycle();
		rst = 1'b0;
	endtask

	task automatic fill_pixels(input bit extreme);
		for (int a = 0; a < N_PIX; a++)
			for (int i = 0; i < `CONV_IN_CH; i++)
				pix_mem[a][i] = extreme ? (rand_bits(1) ? 16'h7fff : 16'h8000) : rand_bits(16);
	endtask

	task automatic fill_coeffs(input bit extreme);
		for (int a = 0; a < N_WT; a++)
			for (int i = 0; i < `CONV_IN_CH; i++)
				if (extreme)
					wt_mem[a][i] = rand_bits(1) ? (16'h7000 | rand_bits(12))
						: (16'h8000 | rand_bits(12));
				else
					wt_mem[a][i] = rand_bits(16);
		for (int ch = 0; ch < `CONV_OUT_CH; ch++)
			if (extreme)
				bias_mem[ch] = (ch % 2) ? 16'h7fff - rand_bits(4) : 16'h8000 + rand_bits(4);
			else
				bias_mem[ch] = rand_bits(16);
	endtask

	task automatic check_quiet(input int n);
		repeat (n)
		begin
			next_cycle();
			if (save_enable)
				report_error("save_enable high after the end of the frame");
			if (calculation_done)
				report_error("calculation_done high again after its pulse");
			if (read_pixel_signal || read_weight_signal || read_bias_signal)
				report_error("read strobe high while the DUT should be idle");
		end
	endtask

	// starts at strobe 0 when started is set, otherwise requests a frame first
	task automatic run_frame(input bit started);
		int wait_cyc;
		int k;
		int s;
		int orow;
		int ocol;
		int p;
		bit done_seen;
		int strobe_at [N_PIX];
		logic [15:0] exp_val;
		wait_cyc = 0;
		k = 0;
		s = 0;
		done_seen = 0;
		frame_done_seen = 0;
		if (!started)
		begin
			pixel_store_done = 1'b1;
			while (!read_pixel_signal && wait_cyc < WAIT_LIMIT)
			begin
				next_cycle();
				wait_cyc++;
			end
			pixel_store_done = 1'b0;
			if (!read_pixel_signal)
			begin
				report_error("timeout waiting for the first pixel read");
				return;
			end
		end
		for (int lc = 0; lc < WAIT_LIMIT && !done_seen; lc++)
		begin
			if (lc > 0)
				next_cycle();
			if (read_weight_signal || read_bias_signal)
				report_error("coefficient read during a frame");
			if (read_pixel_signal)
			begin
				if (k >= N_PIX)
					report_error("more pixel reads than one frame holds");
				else
				begin
					if (lc != k)
						report_error("pixel read strobes are not consecutive");
					if (read_row_addr != 16'(k / W))
						report_mismatch("read_row_addr", k / W, read_row_addr);
					if (read_col_addr != 16'(k % W))
						report_mismatch("read_col_addr", k % W, read_col_addr);
					strobe_at[k] = lc;
				end
				k++;
			end
			if (save_enable)
			begin
				if (s >= N_SAVE)
					report_error("more saves than output positions");
				else
				begin
					orow = s / OUT_W;
					ocol = s % OUT_W;
					p = (orow + 2) * W + ocol + 2;
					if (output_row != 16'(orow))
						report_mismatch("output_row", orow, output_row);
					if (output_col != 16'(ocol))
						report_mismatch("output_col", ocol, output_col);
					if (p >= k || lc != strobe_at[p] + 4)
						report_error($sformatf("save %0d not 4 cycles after its pixel read", s));
					for (int ch = 0; ch < `CONV_OUT_CH; ch++)
					begin
						exp_val = model_result(orow, ocol, ch);
						if (output_data[ch] !== exp_val)
							report_mismatch($sformatf("output_data[%0d] at (%0d,%0d)", ch, orow, ocol),
								exp_val, output_data[ch]);
					end
				end
				s++;
			end
			if (calculation_done)
			begin
				done_seen = 1;
				done_with_save = save_enable;
				done_row = output_row;
				done_col = output_col;
			end
		end
		frame_done_seen = done_seen;
		if (!done_seen)
			report_error("timeout waiting for calculation_done");
		if (k != N_PIX)
			report_mismatch("pixel read count", N_PIX, k);
		if (s != N_SAVE)
			report_mismatch("save count", N_SAVE, s);
	endtask

	task automatic reset_state_test();
		int errs0;
		errs0 = errors;
		apply_reset();
		repeat (3)
		begin
			next_cycle();
			if (save_enable || calculation_done || read_pixel_signal
				|| read_weight_signal || read_bias_signal)
				report_error("control output high after reset");
		end
		finish_test("reset state", errs0);
	endtask

	// pixel_store_done is already high, so the frame must wait for the load
	task automatic coeff_load_test();
		int errs0;
		int cyc;
		int w_cnt;
		int b_cnt;
		bit w_end;
		bit b_end;
		errs0 = errors;
		cyc = 0;
		w_cnt = 0;
		b_cnt = 0;
		w_end = 0;
		b_end = 0;
		weight_store_done = 1'b1;
		pixel_store_done = 1'b1;
		while (!frame_started && cyc < WAIT_LIMIT)
		begin
			next_cycle();
			cyc++;
			if (read_weight_signal)
			begin
				if (w_end)
					report_error("weight reads resumed after they stopped");
				if (read_weight_addr != 16'(w_cnt))
					report_mismatch("read_weight_addr", w_cnt, read_weight_addr);
				w_cnt++;
			end
			else if (w_cnt > 0)
				w_end = 1;
			if (read_bias_signal)
			begin
				if (b_end)
					report_error("bias reads resumed after they stopped");
				if (read_bias_addr != 16'(b_cnt))
					report_mismatch("read_bias_addr", b_cnt, read_bias_addr);
				b_cnt++;
			end
			else if (b_cnt > 0)
				b_end = 1;
			if (read_pixel_signal)
			begin
				frame_started = 1;
				if (read_weight_signal || read_bias_signal || w_cnt != N_WT)
					report_error("pixel read before the coefficient load finished");
			end
		end
		pixel_store_done = 1'b0;
		if (!frame_started)
			report_error("timeout waiting for the frame after the coefficient load");
		if (w_cnt != N_WT)
			report_mismatch("weight read count", N_WT, w_cnt);
		if (b_cnt != `CONV_OUT_CH)
			report_mismatch("bias read count", `CONV_OUT_CH, b_cnt);
		finish_test("coefficient load", errs0);
	endtask

	task automatic first_frame_test();
		int errs0;
		errs0 = errors;
		run_frame(frame_started);
		finish_test("first frame", errs0);
	endtask

	task automatic done_pulse_test();
		int errs0;
		errs0 = errors;
		if (!frame_done_seen)
			report_error("no calculation_done in the first frame");
		else
		begin
			if (!done_with_save)
				report_error("calculation_done without save_enable");
			if (done_row != 16'(`CONV_IMG_H - 3))
				report_mismatch("output_row at done", `CONV_IMG_H - 3, done_row);
			if (done_col != 16'(OUT_W - 1))
				report_mismatch("output_col at done", OUT_W - 1, done_col);
		end
		check_quiet(10);
		finish_test("done pulse", errs0);
	endtask

	task automatic second_frame_test();
		int errs0;
		errs0 = errors;
		fill_pixels(0);
		run_frame(0);
		check_quiet(4);
		finish_test("second frame", errs0);
	endtask

	// new coefficients need a fresh reset and load
	task automatic extreme_values_test();
		int errs0;
		errs0 = errors;
		fill_pixels(1);
		fill_coeffs(1);
		weight_store_done = 1'b0;
		apply_reset();
		weight_store_done = 1'b1;
		run_frame(0);
		check_quiet(4);
		finish_test("extreme values", errs0);
	endtask

	initial
	begin
		rst = 1'b1;
		weight_store_done = 1'b0;
		pixel_store_done = 1'b0;
		input_data = '0;
		weight_data = '0;
		bias_data = '0;
		lfsr = 32'h2826_3daf;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		frame_started = 0;
		frame_done_seen = 0;
		fill_pixels(0);
		fill_coeffs(0);
		reset_state_test();
		coeff_load_test();
		first_frame_test();
		done_pulse_test();
		second_frame_test();
		extreme_values_test();
		$display("tests run %0d, failed %0d, total errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== hw/channel_mac.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module channel_mac (
	input  logic                  clk,
	input  logic                  rst,
	input  conv_pkg::window_t     window,
	input  conv_pkg::chan_coeff_t coeff,
	output conv_pkg::data_t       result
);

	localparam int ACC_W = 2 * `CONV_DATA_W;

	logic signed [ACC_W-1:0] prod;
	logic signed [ACC_W-1:0] sum;

	always_comb
	begin
		// bias sign extended to the accumulator
		sum = {{(ACC_W - `CONV_DATA_W){coeff.bias[`CONV_DATA_W-1]}}, coeff.bias};
		prod = '0;
		for (int t = 0; t < `CONV_TAPS; t++)
		begin
			for (int i = 0; i < `CONV_IN_CH; i++)
			begin
				prod = $signed(window[t][i]) * $signed(coeff.weights[t][i]);
				sum = sum + (prod >>> `CONV_FRAC);
			end
		end
	end

	// low half only, overflow wraps
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			result <= '0;
		else
			result <= sum[`CONV_DATA_W-1:0];
	end

endmodule

// ==== hw/coeff_loader.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module coeff_loader (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    weight_store_done,
	input  conv_pkg::pixel_t        weight_data,
	input  conv_pkg::data_t         bias_data,
	output logic                    read_weight_signal,
	output logic                    read_bias_signal,
	output logic                    coeff_ready,
	output logic [`CONV_ADDR_W-1:0] read_weight_addr,
	output logic [`CONV_ADDR_W-1:0] read_bias_addr,
	output conv_pkg::coeff_set_t    coeffs
);

	localparam int W_WORDS = `CONV_TAPS * `CONV_OUT_CH;
	localparam int B_WORDS = `CONV_OUT_CH;

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_LOAD,
		LD_HELD
	} ld_state_t;

	ld_state_t w_state;
	ld_state_t b_state;
	logic [`CONV_ADDR_W-1:0] w_addr;
	logic [`CONV_ADDR_W-1:0] b_addr;
	logic w_last;
	logic b_last;
	logic w_capture;
	logic b_capture;

	// newest word enters at the top index
	conv_pkg::pixel_t [W_WORDS-1:0] w_chain;
	conv_pkg::data_t [B_WORDS-1:0] b_chain;

	function automatic ld_state_t ld_next(ld_state_t cur, logic start, logic last);
		case (cur)
			LD_IDLE:
				return start ? LD_LOAD : LD_IDLE;
			LD_LOAD:
				return last ? LD_HELD : LD_LOAD;
			LD_HELD:
				return LD_HELD;
			default:
				return LD_IDLE;
		endcase
	endfunction

	assign w_last = (w_addr == `CONV_ADDR_W'(W_WORDS - 1));
	assign b_last = (b_addr == `CONV_ADDR_W'(B_WORDS - 1));

	assign read_weight_signal = (w_state == LD_LOAD);
	assign read_bias_signal = (b_state == LD_LOAD);
	assign read_weight_addr = w_addr;
	assign read_bias_addr = b_addr;

	// both reads start together, bias finishes first
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_state <= LD_IDLE;
			b_state <= LD_IDLE;
			w_addr <= '0;
			b_addr <= '0;
		end
		else
		begin
			w_state <= ld_next(w_state, weight_store_done, w_last);
			b_state <= ld_next(b_state, weight_store_done, b_last);
			w_addr <= (read_weight_signal && !w_last) ? w_addr + 1'b1 : '0;
			b_addr <= (read_bias_signal && !b_last) ? b_addr + 1'b1 : '0;
		end
	end

	// memory answers one cycle after the strobe
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_capture <= 1'b0;
			b_capture <= 1'b0;
			coeff_ready <= 1'b0;
		end
		else
		begin
			w_capture <= read_weight_signal;
			b_capture <= read_bias_signal;
			if (w_capture && w_state == LD_HELD)
				coeff_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (w_capture)
			w_chain <= {weight_data, w_chain[W_WORDS-1:1]};
		if (b_capture)
			b_chain <= {bias_data, b_chain[B_WORDS-1:1]};
	end

	// word a sits at index a once the chain is full
	always_comb
	begin
		for (int ch = 0; ch < `CONV_OUT_CH; ch++)
		begin
			for (int t = 0; t < `CONV_TAPS; t++)
			begin
				coeffs[ch].weights[t] = w_chain[t * `CONV_OUT_CH + ch];
			end
			coeffs[ch].bias = b_chain[ch];
		end
	end

endmodule

// ==== hw/conv_pkg.sv ====
`include "conv_macros.svh"

package conv_pkg;

	// one signed lane
	typedef logic signed [`CONV_DATA_W-1:0] data_t;

	// lane i is input channel i
	typedef data_t [`CONV_IN_CH-1:0] pixel_t;

	// tap 0 is top-left and oldest, row-major
	typedef pixel_t [`CONV_TAPS-1:0] window_t;

	// coefficients of one output channel
	typedef struct packed {
		pixel_t [`CONV_TAPS-1:0] weights;
		data_t                   bias;
	} chan_coeff_t;

	typedef chan_coeff_t [`CONV_OUT_CH-1:0] coeff_set_t;

	// element j is output channel j
	typedef data_t [`CONV_OUT_CH-1:0] result_t;

endpackage

// ==== hw/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_top (
	input  logic                    clk,
	input  logic                    rst,
	input  conv_pkg::pixel_t        input_data,
	input  conv_pkg::pixel_t        weight_data,
	input  conv_pkg::data_t         bias_data,
	input  logic                    weight_store_done,
	input  logic                    pixel_store_done,
	output logic                    save_enable,
	output logic                    calculation_done,
	output logic                    read_pixel_signal,
	output logic                    read_weight_signal,
	output logic                    read_bias_signal,
	output logic [`CONV_ADDR_W-1:0] output_row,
	output logic [`CONV_ADDR_W-1:0] output_col,
	output logic [`CONV_ADDR_W-1:0] read_row_addr,
	output logic [`CONV_ADDR_W-1:0] read_col_addr,
	output logic [`CONV_ADDR_W-1:0] read_weight_addr,
	output logic [`CONV_ADDR_W-1:0] read_bias_addr,
	output conv_pkg::result_t       output_data
);

	conv_pkg::window_t    window;
	conv_pkg::coeff_set_t coeffs;
	conv_pkg::result_t    results;
	logic                 coeff_ready;

	window_gen u_window (
		.clk    (clk),
		.rst    (rst),
		.pixel  (input_data),
		.window (window)
	);

	coeff_loader u_coeff (
		.clk                (clk),
		.rst                (rst),
		.weight_store_done  (weight_store_done),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.read_weight_signal (read_weight_signal),
		.read_bias_signal   (read_bias_signal),
		.coeff_ready        (coeff_ready),
		.read_weight_addr   (read_weight_addr),
		.read_bias_addr     (read_bias_addr),
		.coeffs             (coeffs)
	);

	// one unit per output channel, all sharing the window
	for (genvar j = 0; j < `CONV_OUT_CH; j++)
	begin : g_chan
		channel_mac u_mac (
			.clk    (clk),
			.rst    (rst),
			.window (window),
			.coeff  (coeffs[j]),
			.result (results[j])
		);
	end

	save_ctrl u_save (
		.clk               (clk),
		.rst               (rst),
		.pixel_store_done  (pixel_store_done),
		.coeff_ready       (coeff_ready),
		.results           (results),
		.read_pixel_signal (read_pixel_signal),
		.save_enable       (save_enable),
		.calculation_done  (calculation_done),
		.read_row_addr     (read_row_addr),
		.read_col_addr     (read_col_addr),
		.output_row        (output_row),
		.output_col        (output_col),
		.output_data       (output_data)
	);

endmodule

// ==== hw/save_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module save_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    pixel_store_done,
	input  logic                    coeff_ready,
	input  conv_pkg::result_t       results,
	output logic                    read_pixel_signal,
	output logic                    save_enable,
	output logic                    calculation_done,
	output logic [`CONV_ADDR_W-1:0] read_row_addr,
	output logic [`CONV_ADDR_W-1:0] read_col_addr,
	output logic [`CONV_ADDR_W-1:0] output_row,
	output logic [`CONV_ADDR_W-1:0] output_col,
	output conv_pkg::result_t       output_data
);

	// strobe to channel result register
	localparam int DELAY = 3;
	// first row and column with a full window
	localparam int EDGE = 2;

	typedef enum logic {
		RD_IDLE,
		RD_ACTIVE
	} rd_state_t;

	typedef struct packed {
		logic                    valid;
		logic [`CONV_ADDR_W-1:0] row;
		logic [`CONV_ADDR_W-1:0] col;
	} pos_tag_t;

	rd_state_t state;
	logic [`CONV_ADDR_W-1:0] row_cnt;
	logic [`CONV_ADDR_W-1:0] col_cnt;
	logic last_col;
	logic last_pixel;
	pos_tag_t tag_in;
	pos_tag_t tag_out;
	pos_tag_t [DELAY-1:0] tag_q;

	assign last_col = (col_cnt == `CONV_ADDR_W'(`CONV_IMG_W - 1));
	assign last_pixel = last_col && (row_cnt == `CONV_ADDR_W'(`CONV_IMG_H - 1));

	assign read_pixel_signal = (state == RD_ACTIVE);
	assign read_row_addr = row_cnt;
	assign read_col_addr = col_cnt;

	// raster scan of one frame
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= RD_IDLE;
			row_cnt <= '0;
			col_cnt <= '0;
		end
		else
		begin
			case (state)
				RD_IDLE:
				begin
					if (pixel_store_done && coeff_ready)
						state <= RD_ACTIVE;
				end
				RD_ACTIVE:
				begin
					if (last_col)
					begin
						col_cnt <= '0;
						if (last_pixel)
						begin
							row_cnt <= '0;
							state <= RD_IDLE;
						end
						else
							row_cnt <= row_cnt + 1'b1;
					end
					else
						col_cnt <= col_cnt + 1'b1;
				end
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	assign tag_in = '{valid: read_pixel_signal, row: row_cnt, col: col_cnt};
	assign tag_out = tag_q[DELAY-1];

	// follows each read down to the result register
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			tag_q <= '0;
		else
			tag_q <= {tag_q[DELAY-2:0], tag_in};
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			save_enable <= 1'b0;
			calculation_done <= 1'b0;
			output_row <= '0;
			output_col <= '0;
		end
		else
		begin
			save_enable <= tag_out.valid && tag_out.row >= `CONV_ADDR_W'(EDGE)
				&& tag_out.col >= `CONV_ADDR_W'(EDGE);
			calculation_done <= tag_out.valid
				&& tag_out.row == `CONV_ADDR_W'(`CONV_IMG_H - 1)
				&& tag_out.col == `CONV_ADDR_W'(`CONV_IMG_W - 1);
			output_row <= tag_out.row - `CONV_ADDR_W'(EDGE);
			output_col <= tag_out.col - `CONV_ADDR_W'(EDGE);
		end
	end

	always_ff @(posedge clk)
	begin
		output_data <= results;
	end

endmodule

// ==== hw/window_gen.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module window_gen (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::pixel_t  pixel,
	output conv_pkg::window_t window
);

	// pixels between the last tap of one row and the first of the next
	localparam int LINE_LEN = `CONV_IMG_W - 3;

	conv_pkg::pixel_t [LINE_LEN-1:0] line_mid;
	conv_pkg::pixel_t [LINE_LEN-1:0] line_top;

	// index 0 of each line delay is its newest stage
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			window <= '0;
			line_mid <= '0;
			line_top <= '0;
		end
		else
		begin
			// bottom row, newest pixel at tap 8
			window[8] <= pixel;
			window[7] <= window[8];
			window[6] <= window[7];

			line_mid <= {line_mid[LINE_LEN-2:0], window[6]};

			// middle row, one image line older
			window[5] <= line_mid[LINE_LEN-1];
			window[4] <= window[5];
			window[3] <= window[4];

			line_top <= {line_top[LINE_LEN-2:0], window[3]};

			// top row
			window[2] <= line_top[LINE_LEN-1];
			window[1] <= window[2];
			window[0] <= window[1];
		end
	end

endmodule

// ==== include/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// lane width and channel counts
`define CONV_DATA_W 16
`define CONV_IN_CH 2
`define CONV_OUT_CH 4

// frame size in pixels
`define CONV_IMG_W 8
`define CONV_IMG_H 6

// 3x3 window
`define CONV_TAPS 9

// products are shifted right by this many bits
`define CONV_FRAC 8

`define CONV_ADDR_W 16

`endif

// ==== sim.f ====
+incdir+include
hw/conv_pkg.sv
hw/window_gen.sv
hw/coeff_loader.sv
hw/channel_mac.sv
hw/save_ctrl.sv
hw/conv_top.sv
dv/conv_tb.sv
